/* rtl/stage2_cnn_pkg.sv */
package stage2_cnn_pkg;

    // Channel count of one feature-map point.
    localparam int ST2_CI = 3;

    // Width of one signed channel value.
    localparam int ST2_IBW = 19;

    // Largest positive value of a channel.
    localparam logic signed [ST2_IBW-1:0] ST2_ACC_MAX = {1'b0, {(ST2_IBW-1){1'b1}}};

    // One signed channel value.
    // The named type keeps each element of a packed array signed.
    typedef logic signed [ST2_IBW-1:0] st2_data_t;

    // One feature-map point with all channels, channel 0 in the low bits.
    typedef struct packed {
        st2_data_t [ST2_CI-1:0] ch;
    } st2_point_t;

    // Host write to one bias register.
    typedef struct packed {
        logic      we;     // Write strobe.
        logic [1:0] ch;    // Channel index.
        st2_data_t value;  // New bias value.
    } st2_bias_wr_t;

endpackage

/* rtl/stage2_act_core.sv */
`timescale 1ns/1ps

module stage2_act_core (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         i_in_valid,
    input  stage2_cnn_pkg::st2_point_t   i_in_fmap,
    input  stage2_cnn_pkg::st2_bias_wr_t i_bias_wr,
    output logic                         o_act_valid,
    output stage2_cnn_pkg::st2_point_t   o_act_fmap
);

    import stage2_cnn_pkg::*;

    st2_data_t              r_bias [ST2_CI];
    logic signed [ST2_IBW:0] w_sum [ST2_CI];  // One extra bit so the add cannot wrap.
    st2_point_t             w_act;

    // Bias registers, written by the host between frames.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int c = 0; c < ST2_CI; c++) begin
                r_bias[c] <= '0;
            end
        end else begin
            for (int c = 0; c < ST2_CI; c++) begin
                if (i_bias_wr.we && (i_bias_wr.ch == 2'(c))) begin
                    r_bias[c] <= i_bias_wr.value;  // Index 3 matches no channel.
                end
            end
        end
    end

    // Bias add, saturation and ReLU per channel.
    always_comb begin
        for (int c = 0; c < ST2_CI; c++) begin
            w_sum[c] = {i_in_fmap.ch[c][ST2_IBW-1], i_in_fmap.ch[c]}
                     + {r_bias[c][ST2_IBW-1], r_bias[c]};
            if (w_sum[c] > ST2_ACC_MAX) begin
                w_act.ch[c] = ST2_ACC_MAX;
            end else if (w_sum[c] < 0) begin
                w_act.ch[c] = '0;
            end else begin
                w_act.ch[c] = w_sum[c][ST2_IBW-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_act_valid <= 1'b0;
        end else begin
            o_act_valid <= i_in_valid;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_act_fmap <= '0;
        end else if (i_in_valid) begin
            o_act_fmap <= w_act;  // Held between points.
        end
    end

endmodule

/* rtl/stage2_pooling.sv */
`timescale 1ns/1ps

module stage2_pooling #(
    parameter int IMG_W = 16,
    parameter int IMG_H = 8
) (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      i_in_valid,
    input  logic signed [stage2_cnn_pkg::ST2_IBW-1:0] i_in_fmap,
    output logic                                      o_ot_valid,
    output logic signed [stage2_cnn_pkg::ST2_IBW-1:0] o_ot_fmap
);

    import stage2_cnn_pkg::*;

    localparam int COL_W  = $clog2(IMG_W);
    localparam int ROW_W  = $clog2(IMG_H);
    localparam int HALF_W = IMG_W / 2;

    logic [COL_W-1:0]   r_col;
    logic [ROW_W-1:0]   r_row;
    logic [COL_W-2:0]   w_idx;
    logic               w_col_last;
    logic               w_row_last;
    logic               w_win_done;
    st2_data_t          r_pair;
    st2_data_t          r_line [HALF_W];  // Pair maxima of the even row.
    st2_data_t          w_line_rd;
    st2_data_t          w_pair_max;
    st2_data_t          w_win_max;

    assign w_idx      = r_col[COL_W-1:1];
    assign w_col_last = (r_col == COL_W'(IMG_W - 1));
    assign w_row_last = (r_row == ROW_W'(IMG_H - 1));

    // A window closes on the odd column of an odd row.
    assign w_win_done = i_in_valid & r_col[0] & r_row[0];

    // Position of the next accepted point, row-major.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_col <= '0;
            r_row <= '0;
        end else if (i_in_valid) begin
            if (w_col_last) begin
                r_col <= '0;
                if (w_row_last) begin
                    r_row <= '0;  // Next frame.
                end else begin
                    r_row <= r_row + 1'b1;
                end
            end else begin
                r_col <= r_col + 1'b1;
            end
        end
    end

    assign w_line_rd  = r_line[w_idx];
    assign w_pair_max = (i_in_fmap > r_pair) ? i_in_fmap : r_pair;
    assign w_win_max  = (w_pair_max > w_line_rd) ? w_pair_max : w_line_rd;

    // Left pixel of each horizontal pair.
    always_ff @(posedge clk) begin
        if (i_in_valid && !r_col[0]) begin
            r_pair <= i_in_fmap;
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid && r_col[0] && !r_row[0]) begin
            r_line[w_idx] <= w_pair_max;  // Upper half of the window.
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
        end else begin
            o_ot_valid <= w_win_done;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_fmap <= '0;
        end else if (w_win_done) begin
            o_ot_fmap <= w_win_max;
        end
    end

endmodule

/* rtl/stage2_pooling_core.sv */
`timescale 1ns/1ps

module stage2_pooling_core #(
    parameter int IMG_W = 16,
    parameter int IMG_H = 8
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_in_valid,
    input  stage2_cnn_pkg::st2_point_t i_in_fmap,
    output logic                       o_ot_valid,
    output stage2_cnn_pkg::st2_point_t o_ot_fmap
);

    import stage2_cnn_pkg::*;

    logic [ST2_CI-1:0] w_ot_valid;
    st2_point_t        w_ot_fmap;
    logic              w_all_valid;

    for (genvar g = 0; g < ST2_CI; g++) begin : g_ch
        stage2_pooling #(
            .IMG_W (IMG_W),
            .IMG_H (IMG_H)
        ) u_stage2_pooling (
            .clk        (clk),
            .reset_n    (reset_n),
            .i_in_valid (i_in_valid),  // Same strobe for every channel.
            .i_in_fmap  (i_in_fmap.ch[g]),
            .o_ot_valid (w_ot_valid[g]),
            .o_ot_fmap  (w_ot_fmap.ch[g])
        );
    end

    // The instances run in lockstep, so all valids rise together.
    assign w_all_valid = &w_ot_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
        end else begin
            o_ot_valid <= w_all_valid;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_fmap <= '0;
        end else if (w_all_valid) begin
            o_ot_fmap <= w_ot_fmap;  // Holds its value between pulses.
        end
    end

endmodule

/* rtl/stage2_post_top.sv */
`timescale 1ns/1ps

module stage2_post_top #(
    parameter int IMG_W = 16,  // Must be even.
    parameter int IMG_H = 8    // Must be even.
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         i_in_valid,
    input  stage2_cnn_pkg::st2_point_t   i_in_fmap,
    input  stage2_cnn_pkg::st2_bias_wr_t i_bias_wr,
    output logic                         o_ot_valid,
    output stage2_cnn_pkg::st2_point_t   o_ot_fmap
);

    import stage2_cnn_pkg::*;

    logic       act_valid;
    st2_point_t act_fmap;

    stage2_act_core u_act_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (i_in_valid),
        .i_in_fmap   (i_in_fmap),
        .i_bias_wr   (i_bias_wr),
        .o_act_valid (act_valid),
        .o_act_fmap  (act_fmap)
    );

    stage2_pooling_core #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_pooling_core (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (act_valid),
        .i_in_fmap  (act_fmap),
        .o_ot_valid (o_ot_valid),
        .o_ot_fmap  (o_ot_fmap)
    );

endmodule

/* verif/stage2_post_model.svh */
`ifndef STAGE2_POST_MODEL_SVH
`define STAGE2_POST_MODEL_SVH

st2_data_t  bias_model [ST2_CI] = '{default: '0};
st2_point_t upper_row [TB_IMG_W];  // Activated points of the last even row.
st2_point_t left_pt;               // Left point of the current pair in an odd row.
int         m_col = 0;
int         m_row = 0;

st2_point_t exp_fmap_q [$];
int         exp_cyc_q [$];
int         exp_tag_q [$];

// Bias add, clamp to the positive limit and ReLU.
function automatic st2_data_t activate(input st2_data_t x, input st2_data_t b);
    int s;
    s = int'(x) + int'(b);
    if (s > ACT_LIMIT) begin
        s = ACT_LIMIT;
    end
    if (s < 0) begin
        s = 0;
    end
    return st2_data_t'(s);
endfunction

function automatic st2_data_t larger(input st2_data_t a, input st2_data_t b);
    return (a >= b) ? a : b;
endfunction

// One accepted input point; a closed window pushes its expected output.
task automatic predict_point(input st2_point_t pt, input int cycle, input int tag);
    st2_point_t act;
    st2_point_t win;
    for (int c = 0; c < ST2_CI; c++) begin
        act.ch[c] = activate(pt.ch[c], bias_model[c]);
    end
    if (m_row % 2 == 0) begin
        upper_row[m_col] = act;
    end else if (m_col % 2 == 0) begin
        left_pt = act;
    end else begin
        for (int c = 0; c < ST2_CI; c++) begin
            win.ch[c] = larger(larger(upper_row[m_col-1].ch[c], upper_row[m_col].ch[c]),
                               larger(left_pt.ch[c], act.ch[c]));
        end
        exp_fmap_q.push_back(win);
        exp_cyc_q.push_back(cycle + PIPE_LATENCY);
        exp_tag_q.push_back(tag);
    end
    m_col++;
    if (m_col == TB_IMG_W) begin
        m_col = 0;
        m_row = (m_row == TB_IMG_H - 1) ? 0 : m_row + 1;
    end
endtask

// Channel index 3 has no register and is dropped.
task automatic track_bias_write(input st2_bias_wr_t wr);
    if (wr.we && (int'(wr.ch) < ST2_CI)) begin
        bias_model[wr.ch] = wr.value;
    end
endtask

`endif

/* verif/tb_stage2_post_top.sv */
`timescale 1ns/1ps

module tb_stage2_post_top;

    import stage2_cnn_pkg::*;

    localparam int TB_IMG_W       = 16;
    localparam int TB_IMG_H       = 8;
    localparam int NUM_FRAMES     = 6;
    localparam int PIPE_LATENCY   = 3;
    localparam int ACT_LIMIT      = (1 << (ST2_IBW - 1)) - 1;
    localparam int EXP_OUTPUTS    = NUM_FRAMES * (TB_IMG_W / 2) * (TB_IMG_H / 2);
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * TB_IMG_W * TB_IMG_H * 4 + 200;

    localparam int KIND_RAND = 0;
    localparam int KIND_SAT  = 1;
    localparam int KIND_RELU = 2;
    localparam int KIND_POS  = 3;

    logic         clk = 1'b0;
    logic         reset_n;
    logic         i_in_valid;
    st2_point_t   i_in_fmap;
    st2_bias_wr_t i_bias_wr;
    logic         o_ot_valid;
    st2_point_t   o_ot_fmap;
    logic [1:0]   frame_tag;  // Travels with each point to mark the kind of frame.

    int seed      = 32'h7188_654f;
    int cyc       = 0;
    int out_count = 0;

    `include "stage2_post_model.svh"

    stage2_post_top #(
        .IMG_W (TB_IMG_W),
        .IMG_H (TB_IMG_H)
    ) i_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_fmap  (i_in_fmap),
        .i_bias_wr  (i_bias_wr),
        .o_ot_valid (o_ot_valid),
        .o_ot_fmap  (o_ot_fmap)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("FAILED at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        i_in_valid <= 1'b0;
        i_bias_wr  <= '0;
    endtask

    task automatic drive_point(input st2_point_t pt, input int kind);
        @(posedge clk);
        i_in_valid <= 1'b1;
        i_in_fmap  <= pt;
        i_bias_wr  <= '0;
        frame_tag  <= 2'(kind);
    endtask

    task automatic write_bias(input logic [1:0] ch, input st2_data_t value);
        @(posedge clk);
        i_in_valid <= 1'b0;
        i_bias_wr  <= '{we: 1'b1, ch: ch, value: value};
    endtask

    // One frame in row-major order, with a gap chance in percent before each point.
    task automatic send_frame(input int kind, input int gap_pct);
        st2_point_t  pt;
        logic [31:0] rnd;
        int          p;
        int          target;
        for (int r = 0; r < TB_IMG_H; r++) begin
            for (int c = 0; c < TB_IMG_W; c++) begin
                for (int ch = 0; ch < ST2_CI; ch++) begin
                    rnd    = $random(seed);
                    p      = (r % 2) * 2 + (c % 2);  // Position inside the 2x2 window.
                    target = (ch + (r / 2) * (TB_IMG_W / 2) + c / 2) % 4;
                    case (kind)
                        KIND_SAT:  pt.ch[ch] = ST2_ACC_MAX - st2_data_t'(rnd[7:0]);
                        KIND_RELU: pt.ch[ch] = st2_data_t'(-2000 - int'(rnd[15:0]));
                        KIND_POS:  pt.ch[ch] = st2_data_t'(int'(rnd[9:0])
                                                 + ((p == target) ? 20000 : 0));
                        default:   pt.ch[ch] = rnd[ST2_IBW-1:0];
                    endcase
                end
                rnd = $random(seed);
                while ((rnd % 100) < gap_pct) begin
                    idle_cycle();
                    rnd = $random(seed);
                end
                drive_point(pt, kind);
            end
        end
        idle_cycle();
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the pooled stream did not finish in time");
        end
    end

    // The point is predicted before the bias write of the same cycle takes effect.
    always @(posedge clk) begin
        if (reset_n && i_in_valid) begin
            predict_point(i_in_fmap, cyc, int'(frame_tag));
        end
        if (reset_n) begin
            track_bias_write(i_bias_wr);
        end
    end

    assert property (@(posedge clk) !reset_n |-> !o_ot_valid)
        else abort_run("o_ot_valid was high during reset");

    always @(posedge clk) begin : check_output
        st2_point_t exp_pt;
        int         exp_cyc;
        int         exp_tag;
        if (reset_n && o_ot_valid) begin
            assert (exp_fmap_q.size() != 0)
                else abort_run("o_ot_valid pulsed with no completed window");
            exp_pt  = exp_fmap_q.pop_front();
            exp_cyc = exp_cyc_q.pop_front();
            exp_tag = exp_tag_q.pop_front();
            assert (o_ot_fmap == exp_pt)
                else report_mismatch("o_ot_fmap", 64'(exp_pt), 64'(o_ot_fmap));
            assert (cyc == exp_cyc)
                else report_mismatch("o_ot_valid cycle", 64'(exp_cyc), 64'(cyc));
            if (exp_tag == KIND_SAT) begin
                for (int c = 0; c < ST2_CI; c++) begin
                    assert (o_ot_fmap.ch[c] == ST2_ACC_MAX)
                        else report_mismatch("o_ot_fmap.ch", 64'(ST2_ACC_MAX),
                                             64'(o_ot_fmap.ch[c]));
                end
            end
            if (exp_tag == KIND_RELU) begin
                assert (o_ot_fmap == '0)
                    else report_mismatch("o_ot_fmap", 64'(0), 64'(o_ot_fmap));
            end
            out_count++;
        end
    end

    initial begin
        reset_n    = 1'b0;
        i_in_valid = 1'b0;
        i_in_fmap  = '0;
        i_bias_wr  = '0;
        frame_tag  = '0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;

        write_bias(2'd0, 19'sd1000);
        write_bias(2'd1, -19'sd500);
        write_bias(2'd2, 19'sd0);
        write_bias(2'd3, 19'sd12345);  // No such channel.
        send_frame(KIND_RAND, 0);
        send_frame(KIND_RAND, 30);

        for (int c = 0; c < ST2_CI; c++) begin
            write_bias(2'(c), ST2_ACC_MAX);
        end
        send_frame(KIND_SAT, 0);

        write_bias(2'd0, 19'sd1000);
        write_bias(2'd1, -19'sd500);
        write_bias(2'd2, 19'sd0);
        send_frame(KIND_RELU, 10);

        for (int c = 0; c < ST2_CI; c++) begin
            write_bias(2'(c), 19'sd0);
        end
        send_frame(KIND_POS, 0);

        write_bias(2'd0, -19'sd2000);
        write_bias(2'd1, 19'sd3000);
        write_bias(2'd2, 19'sd700);
        send_frame(KIND_RAND, 40);

        while (exp_fmap_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        if (out_count == EXP_OUTPUTS) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("the number of pooled outputs does not match the frame count");
        end
    end

endmodule

/* stage2_post_top.f */
+incdir+verif
rtl/stage2_cnn_pkg.sv
rtl/stage2_act_core.sv
rtl/stage2_pooling.sv
rtl/stage2_pooling_core.sv
rtl/stage2_post_top.sv
verif/tb_stage2_post_top.sv

/* Makefile */
# Verilator build and run of the stage 2 post-processing testbench.

VERILATOR ?= verilator
TOP       ?= tb_stage2_post_top
FILELIST  ?= stage2_post_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Test failed
PASS_MSG  := Test completed successfully

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verif/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
